// ==== hdl/mdio_cfg.svh ====
`ifndef MDIO_CFG_SVH
`define MDIO_CFG_SVH

// number of independent mdio buses behind the host interface
// works from 1 up to 8 since the port field is 3 bits
`define NUM_PORTS 4

// sys_clk cycles per mdc period, even and at least 4
`define MDC_DIVIDE 8

`endif

// ==== hdl/mdio_frame_pkg.sv ====
package mdio_frame_pkg;

	// clause 45 opcodes as they appear on the wire
	typedef enum logic [1:0] {
		op_addr     = 2'b00,
		op_write    = 2'b01,
		op_read_inc = 2'b10,
		op_read     = 2'b11
	} mdio_op_e;

	// shared by the port engine and the handshake fsms
	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_shift,
		st_done
	} engine_state_e;

	// field widths of one clause 45 frame
	localparam int PREAMBLE_BITS = 32;
	localparam int ST_BITS = 2;
	localparam int OP_BITS = 2;
	localparam int PRTAD_BITS = 5;
	localparam int DEVAD_BITS = 5;
	localparam int TA_BITS = 2;
	localparam int DATA_BITS = 16;

	// bits after the idle bit, 64 in total
	localparam int FRAME_BITS = PREAMBLE_BITS + ST_BITS + OP_BITS + PRTAD_BITS +
		DEVAD_BITS + TA_BITS + DATA_BITS;

endpackage

// ==== hdl/mgmt_if_pkg.sv ====
package mgmt_if_pkg;

	// host port index, wide enough for 8 buses
	localparam int PORT_BITS = 3;

	// host command, 31 bits
	typedef struct packed {
		logic [PORT_BITS-1:0] port;
		mdio_frame_pkg::mdio_op_e op;
		logic [mdio_frame_pkg::PRTAD_BITS-1:0] prtad;
		logic [mdio_frame_pkg::DEVAD_BITS-1:0] devad;
		logic [mdio_frame_pkg::DATA_BITS-1:0] data;
	} mgmt_cmd_t;

	// completion back to the host, 21 bits
	// data is read data, or the line readback for writes and address frames
	typedef struct packed {
		logic [PORT_BITS-1:0] port;
		mdio_frame_pkg::mdio_op_e op;
		logic [mdio_frame_pkg::DATA_BITS-1:0] data;
	} mgmt_rsp_t;

	// split pins of one bus, the pad sits outside
	typedef struct packed {
		logic mdc;
		logic mdo;
		logic mdo_oe;
	} mdio_pins_t;

endpackage

// ==== hdl/mgmt_cmd_dispatch.sv ====
`include "mdio_cfg.svh"

module mgmt_cmd_dispatch (
	input logic sys_clk,
	input logic user_mode_sync,
	input mgmt_if_pkg::mgmt_cmd_t cmd,
	input logic cmd_req,
	output logic cmd_ack,
	output mgmt_if_pkg::mgmt_cmd_t eng_cmd,
	output logic [`NUM_PORTS-1:0] eng_req,
	input logic [`NUM_PORTS-1:0] eng_ack
);
	import mdio_frame_pkg::*;

	// st_load waits for the engine ack, st_shift for its drop,
	// st_done for the host to drop cmd_req
	engine_state_e state;
	logic [`NUM_PORTS-1:0] eng_sel;
	logic [`NUM_PORTS-1:0] port_onehot;
	logic port_ok;
	logic accept;

	assign port_ok = int'(cmd.port) < `NUM_PORTS;
	// out of range ports stay unacknowledged
	assign accept = (state == st_idle) && cmd_req && port_ok;

	always_comb begin
		for (int i = 0; i < `NUM_PORTS; i++) begin
			port_onehot[i] = int'(cmd.port) == i;
		end
	end

	always_ff @(posedge sys_clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			state <= st_idle;
			eng_sel <= '0;
			eng_req <= '0;
			cmd_ack <= 1'b0;
		end else begin
			case (state)
				st_idle: if (accept) begin
					eng_sel <= port_onehot;
					eng_req <= port_onehot;
					state <= st_load;
				end
				// a busy engine holds us here and so holds off the host
				st_load: if (|(eng_ack & eng_sel)) begin
					cmd_ack <= 1'b1;
					eng_req <= '0;
					state <= st_shift;
				end
				st_shift: if (!(|(eng_ack & eng_sel))) state <= st_done;
				st_done: if (!cmd_req) begin
					cmd_ack <= 1'b0;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// command copy, held for the engine until it acks
	always_ff @(posedge sys_clk) begin
		if (accept) eng_cmd <= cmd;
	end

	// host must only address existing ports
	a_port_range: assert property (@(posedge sys_clk) disable iff (!user_mode_sync)
		$rose(cmd_req) |-> port_ok);

endmodule

// ==== hdl/mdio_port_engine.sv ====
`include "mdio_cfg.svh"

module mdio_port_engine #(
	parameter int PORT_IDX = 0
) (
	input logic sys_clk,
	input logic user_mode_sync,
	input mgmt_if_pkg::mgmt_cmd_t eng_cmd,
	input logic eng_req,
	output logic eng_ack,
	output mgmt_if_pkg::mgmt_rsp_t done_rsp,
	output logic done_req,
	input logic done_ack,
	output mgmt_if_pkg::mdio_pins_t pins,
	input logic mdi
);
	import mdio_frame_pkg::*;
	import mgmt_if_pkg::*;

	localparam int DIV_BITS = $clog2(`MDC_DIVIDE);
	localparam int HALF_DIVIDE = `MDC_DIVIDE / 2;

	logic [DIV_BITS-1:0] div_cntr;
	logic mdc_q;
	logic mdc_rise;
	logic mdc_fall;

	engine_state_e state;
	mgmt_cmd_t cmd_q;
	logic [FRAME_BITS:0] dsr;
	logic [FRAME_BITS:0] osr;
	logic [6:0] holding;
	logic [DATA_BITS-1:0] rsr;
	logic is_read;
	logic take_cmd;
	logic load_frame;
	logic shift_frame;
	logic sample_bit;
	logic finish;

	////////////////////
	// mdc divider
	////////////////////

	// free running, strobes line up with the mdc edges
	always_ff @(posedge sys_clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			div_cntr <= '0;
			mdc_q <= 1'b1;
			mdc_rise <= 1'b0;
			mdc_fall <= 1'b0;
		end else begin
			mdc_rise <= 1'b0;
			mdc_fall <= 1'b0;
			if (div_cntr == DIV_BITS'(`MDC_DIVIDE - 1)) begin
				div_cntr <= '0;
				mdc_rise <= 1'b1;
				mdc_q <= 1'b1;
			end else begin
				div_cntr <= div_cntr + 1'b1;
			end
			if (div_cntr == DIV_BITS'(HALF_DIVIDE - 1)) begin
				mdc_fall <= 1'b1;
				mdc_q <= 1'b0;
			end
		end
	end

	////////////////////
	// frame control
	////////////////////

	assign is_read = cmd_q.op inside {op_read, op_read_inc};
	assign take_cmd = (state == st_idle) && eng_req && !eng_ack;
	assign load_frame = (state == st_load) && mdc_fall;
	assign shift_frame = (state == st_shift) && mdc_fall && (holding != '0);
	// last data bit is taken on the rise before holding reaches zero
	assign sample_bit = (state == st_shift) && mdc_rise && (holding != '0);
	assign finish = (state == st_shift) && mdc_rise && (holding == '0);

	always_ff @(posedge sys_clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			state <= st_idle;
			holding <= '0;
			osr <= '0;
			eng_ack <= 1'b0;
			done_req <= 1'b0;
		end else begin
			// ack only from idle, drop once the dispatcher lets go
			if (take_cmd) eng_ack <= 1'b1;
			else if (!eng_req) eng_ack <= 1'b0;

			case (state)
				st_idle: if (take_cmd) state <= st_load;
				st_load: if (load_frame) begin
					// idle bit with oe low, then oe high through the addresses
					// reads release the line for ta and data
					osr <= {1'b0,
						{(PREAMBLE_BITS + ST_BITS + OP_BITS + PRTAD_BITS + DEVAD_BITS){1'b1}},
						{(TA_BITS + DATA_BITS){!is_read}}};
					holding <= 7'(FRAME_BITS + 1);
					state <= st_shift;
				end
				st_shift: if (shift_frame) begin
					osr <= {osr[FRAME_BITS-1:0], 1'b0};
					holding <= holding - 1'b1;
				end else if (finish) begin
					done_req <= 1'b1;
					state <= st_done;
				end
				// hold done_req until the collector acks, then wait for its drop
				st_done: if (done_req) begin
					if (done_ack) done_req <= 1'b0;
				end else if (!done_ack) begin
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	////////////////////
	// data path
	////////////////////

	always_ff @(posedge sys_clk) begin
		if (take_cmd) cmd_q <= eng_cmd;
		// st is 00 for clause 45, ta is 10 when we drive it
		if (load_frame) begin
			dsr <= {1'b0, {PREAMBLE_BITS{1'b1}}, {ST_BITS{1'b0}}, cmd_q.op,
				cmd_q.prtad, cmd_q.devad, 2'b10,
				is_read ? {DATA_BITS{1'b0}} : cmd_q.data};
		end else if (shift_frame) begin
			dsr <= {dsr[FRAME_BITS-1:0], 1'b0};
		end
		// shifts all frame long, only the last 16 samples survive
		if (sample_bit) rsr <= {rsr[DATA_BITS-2:0], mdi};
		// writes report their own drive as seen on the line
		if (finish) begin
			done_rsp.port <= PORT_BITS'(PORT_IDX);
			done_rsp.op <= cmd_q.op;
			done_rsp.data <= rsr;
		end
	end

	assign pins = '{mdc: mdc_q, mdo: dsr[FRAME_BITS], mdo_oe: osr[FRAME_BITS]};

	// phy owns the line for the whole read data phase
	a_read_release: assert property (@(posedge sys_clk) disable iff (!user_mode_sync)
		(state == st_shift) && is_read && (holding != '0) &&
		(holding <= 7'(DATA_BITS)) |-> !pins.mdo_oe);

	// no new command is taken while a frame or completion is pending
	a_ack_idle: assert property (@(posedge sys_clk) disable iff (!user_mode_sync)
		$rose(eng_ack) |-> $past(state) == st_idle);

endmodule

// ==== hdl/mgmt_rsp_collect.sv ====
`include "mdio_cfg.svh"

module mgmt_rsp_collect (
	input logic sys_clk,
	input logic user_mode_sync,
	input mgmt_if_pkg::mgmt_rsp_t done_rsp [`NUM_PORTS],
	input logic [`NUM_PORTS-1:0] done_req,
	output logic [`NUM_PORTS-1:0] done_ack,
	output mgmt_if_pkg::mgmt_rsp_t rsp,
	output logic rsp_req,
	input logic rsp_ack
);
	import mdio_frame_pkg::*;

	localparam int SEL_W = (`NUM_PORTS > 1) ? $clog2(`NUM_PORTS) : 1;

	// st_load waits for rsp_ack, st_shift for its drop,
	// st_done for the engine to drop done_req
	engine_state_e state;
	// port being served, the search starts just after it
	logic [SEL_W-1:0] last_idx;
	logic [SEL_W-1:0] grant_idx;
	logic grant_found;
	logic grab;

	// round-robin search starting after the last port served
	always_comb begin
		grant_found = 1'b0;
		grant_idx = last_idx;
		for (int k = 1; k <= `NUM_PORTS; k++) begin
			if (!grant_found && done_req[(int'(last_idx) + k) % `NUM_PORTS]) begin
				grant_found = 1'b1;
				grant_idx = SEL_W'((int'(last_idx) + k) % `NUM_PORTS);
			end
		end
	end

	assign grab = (state == st_idle) && grant_found;

	always_ff @(posedge sys_clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			state <= st_idle;
			last_idx <= SEL_W'(`NUM_PORTS - 1);
			rsp_req <= 1'b0;
			done_ack <= '0;
		end else begin
			case (state)
				st_idle: if (grab) begin
					last_idx <= grant_idx;
					rsp_req <= 1'b1;
					state <= st_load;
				end
				st_load: if (rsp_ack) begin
					rsp_req <= 1'b0;
					state <= st_shift;
				end
				// host handshake is closed, release the engine now
				st_shift: if (!rsp_ack) begin
					done_ack[last_idx] <= 1'b1;
					state <= st_done;
				end
				st_done: if (!done_req[last_idx]) begin
					done_ack <= '0;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// response copy, engine keeps its own until acked
	always_ff @(posedge sys_clk) begin
		if (grab) rsp <= done_rsp[grant_idx];
	end

	// host may sample rsp at any point while rsp_req is up
	a_rsp_stable: assert property (@(posedge sys_clk) disable iff (!user_mode_sync)
		rsp_req && $past(rsp_req) |-> rsp == $past(rsp));

endmodule

// ==== hdl/mdio_mgmt_top.sv ====
`include "mdio_cfg.svh"

module mdio_mgmt_top (
	input logic sys_clk,
	input logic user_mode_sync,
	input mgmt_if_pkg::mgmt_cmd_t cmd,
	input logic cmd_req,
	output logic cmd_ack,
	output mgmt_if_pkg::mgmt_rsp_t rsp,
	output logic rsp_req,
	input logic rsp_ack,
	output mgmt_if_pkg::mdio_pins_t pins [`NUM_PORTS],
	input logic [`NUM_PORTS-1:0] mdi
);
	import mgmt_if_pkg::*;

	// command fan-out, one shared payload and a req/ack pair per port
	mgmt_cmd_t eng_cmd;
	logic [`NUM_PORTS-1:0] eng_req;
	logic [`NUM_PORTS-1:0] eng_ack;

	// completion fan-in
	mgmt_rsp_t done_rsp [`NUM_PORTS];
	logic [`NUM_PORTS-1:0] done_req;
	logic [`NUM_PORTS-1:0] done_ack;

	mgmt_cmd_dispatch mgmt_cmd_dispatch_i (
		.sys_clk(sys_clk),
		.user_mode_sync(user_mode_sync),
		.cmd(cmd),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.eng_cmd(eng_cmd),
		.eng_req(eng_req),
		.eng_ack(eng_ack)
	);

	// one engine per bus, each tags its completions with its index
	for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_port
		mdio_port_engine #(
			.PORT_IDX(g)
		) mdio_port_engine_i (
			.sys_clk(sys_clk),
			.user_mode_sync(user_mode_sync),
			.eng_cmd(eng_cmd),
			.eng_req(eng_req[g]),
			.eng_ack(eng_ack[g]),
			.done_rsp(done_rsp[g]),
			.done_req(done_req[g]),
			.done_ack(done_ack[g]),
			.pins(pins[g]),
			.mdi(mdi[g])
		);
	end

	mgmt_rsp_collect mgmt_rsp_collect_i (
		.sys_clk(sys_clk),
		.user_mode_sync(user_mode_sync),
		.done_rsp(done_rsp),
		.done_req(done_req),
		.done_ack(done_ack),
		.rsp(rsp),
		.rsp_req(rsp_req),
		.rsp_ack(rsp_ack)
	);

endmodule

// ==== sim/mmd_phy_model.sv ====
module mmd_phy_model #(
	parameter logic [4:0] PRTAD = 5'd0
) (
	input mgmt_if_pkg::mdio_pins_t pins,
	input logic line,
	output logic drive_en,
	output logic drive_val,
	output mdio_frame_pkg::mdio_op_e seen_op,
	output logic [4:0] seen_devad,
	output int frame_cnt,
	output logic frame_err
);
	timeunit 1ns;
	timeprecision 100ps;
	import mdio_frame_pkg::*;

	// sparse mmd space, keyed by {devad, register address}
	logic [15:0] regs [logic [20:0]];
	logic [15:0] addr_reg;
	logic [20:0] key;
	// frame bits seen so far, 0 between frames
	int bit_cnt;
	logic [1:0] op_bits;
	logic [4:0] prtad_bits;
	logic [4:0] devad_bits;
	logic [15:0] data_bits;
	logic [15:0] rd_data;
	logic is_read;

	initial begin
		addr_reg = '0;
		bit_cnt = 0;
		is_read = 1'b0;
		drive_en = 1'b0;
		drive_val = 1'b1;
		frame_cnt = 0;
		frame_err = 1'b0;
	end

	task automatic flag_error(input string what);
		$display("phy at prtad %h: %s", PRTAD, what);
		frame_err = 1'b1;
	endtask

	////////////////////
	// frame decode
	////////////////////

	task automatic take_bit(input int n);
		if (n <= 32) begin
			assert (pins.mdo_oe === 1'b1 && line === 1'b1) else
				flag_error($sformatf("preamble bit %0d is not a driven one", n));
		end else if (n <= 34) begin
			assert (line === 1'b0) else flag_error("start field is not 00");
		end else if (n <= 36) begin
			op_bits = {op_bits[0], line};
		end else if (n <= 41) begin
			prtad_bits = {prtad_bits[3:0], line};
		end else if (n <= 46) begin
			devad_bits = {devad_bits[3:0], line};
			if (n == 46) begin
				assert (prtad_bits == PRTAD) else
					flag_error($sformatf("frame carries prtad %h instead of its own", prtad_bits));
				// read data is fixed before the turnaround starts
				is_read = op_bits[1];
				key = {devad_bits, addr_reg};
				rd_data = regs.exists(key) ? regs[key] : 16'h0000;
			end
		end else if (n <= 48) begin
			if (is_read) begin
				assert (n == 47 || pins.mdo_oe !== 1'b1) else
					flag_error("host still drives the second turnaround bit of a read");
			end else begin
				assert (pins.mdo_oe === 1'b1 && line === ((n == 47) ? 1'b1 : 1'b0)) else
					flag_error("turnaround of a write or address frame is not 10");
			end
		end else begin
			data_bits = {data_bits[14:0], line};
			if (n == 64) close_frame();
		end
	endtask

	// register side effects once the data field is complete
	task automatic close_frame();
		case (mdio_op_e'(op_bits))
			op_addr: addr_reg = data_bits;
			op_write: regs[{devad_bits, addr_reg}] = data_bits;
			op_read_inc: addr_reg = addr_reg + 1'b1;
			default: addr_reg = addr_reg;
		endcase
		seen_op = mdio_op_e'(op_bits);
		seen_devad = devad_bits;
		frame_cnt = frame_cnt + 1;
	endtask

	// the first bit with the host driving marks the start of a frame
	always @(posedge pins.mdc) begin
		if (bit_cnt != 0 || pins.mdo_oe === 1'b1) begin
			bit_cnt = bit_cnt + 1;
			take_bit(bit_cnt);
			if (bit_cnt == 64) bit_cnt = 0;
		end
	end

	////////////////////
	// read drive
	////////////////////

	// drive on the falling edge, the host samples after the next rise
	always @(negedge pins.mdc) begin
		if (is_read && bit_cnt == 47) begin
			drive_en = 1'b1;
			drive_val = 1'b0;
		end else if (is_read && bit_cnt >= 48) begin
			drive_en = 1'b1;
			drive_val = rd_data[63 - bit_cnt];
		end else begin
			drive_en = 1'b0;
		end
	end

endmodule

// ==== sim/mdio_mgmt_tb.sv ====
`include "mdio_cfg.svh"

module mdio_mgmt_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mdio_frame_pkg::*;
	import mgmt_if_pkg::*;

	localparam int NUM_CMDS = 200;
	localparam int SEED = 43579;
	localparam int PRTAD_BASE = 16;
	// one full frame per command plus room for handshakes, mdc alignment and stalls
	localparam int TIMEOUT_CYCLES = NUM_CMDS * ((FRAME_BITS + 1) * `MDC_DIVIDE + 230);
	// quiet time after the last response so a stray frame or response can show up
	localparam int SETTLE_CYCLES = 2 * (FRAME_BITS + 1) * `MDC_DIVIDE;

	// what one response must carry, plus the devad its frame used
	typedef struct packed {
		mdio_op_e op;
		logic [4:0] devad;
		logic [15:0] data;
	} expect_t;

	logic sys_clk;
	logic user_mode_sync;
	mgmt_cmd_t cmd;
	logic cmd_req;
	logic cmd_ack;
	mgmt_rsp_t rsp;
	logic rsp_req;
	logic rsp_ack;
	mdio_pins_t pins [`NUM_PORTS];
	logic [`NUM_PORTS-1:0] mdi;

	// phy model side
	logic [`NUM_PORTS-1:0] phy_oe;
	logic [`NUM_PORTS-1:0] phy_out;
	logic [`NUM_PORTS-1:0] frame_err;
	mdio_op_e seen_op [`NUM_PORTS];
	logic [4:0] seen_devad [`NUM_PORTS];
	int frame_cnt [`NUM_PORTS];

	// reference register model keyed by {port, devad, address}
	logic [15:0] ref_regs [logic [23:0]];
	logic [15:0] ref_addr [`NUM_PORTS];
	expect_t exp_q [`NUM_PORTS][$];
	int served [`NUM_PORTS];
	int rsp_count = 0;
	int unsigned cycle_cnt = 0;

	mdio_mgmt_top mdio_mgmt_top_i (
		.sys_clk(sys_clk),
		.user_mode_sync(user_mode_sync),
		.cmd(cmd),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.rsp(rsp),
		.rsp_req(rsp_req),
		.rsp_ack(rsp_ack),
		.pins(pins),
		.mdi(mdi)
	);

	// host drive wins, then the phy, else the pull-up
	for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_phy
		mmd_phy_model #(
			.PRTAD(5'(PRTAD_BASE + g))
		) mmd_phy_model_i (
			.pins(pins[g]),
			.line(mdi[g]),
			.drive_en(phy_oe[g]),
			.drive_val(phy_out[g]),
			.seen_op(seen_op[g]),
			.seen_devad(seen_devad[g]),
			.frame_cnt(frame_cnt[g]),
			.frame_err(frame_err[g])
		);
		assign mdi[g] = pins[g].mdo_oe ? pins[g].mdo : (phy_oe[g] ? phy_out[g] : 1'b1);
	end

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	////////////////////
	// reference model
	////////////////////

	// register semantics of one clause 45 mmd applied in command order
	function automatic expect_t predict(input mgmt_cmd_t c);
		expect_t e;
		logic [23:0] key;
		int p;
		p = int'(c.port);
		key = {c.port, c.devad, ref_addr[p]};
		e.op = c.op;
		e.devad = c.devad;
		e.data = c.data;
		case (c.op)
			op_addr: ref_addr[p] = c.data;
			op_write: ref_regs[key] = c.data;
			default: begin
				e.data = ref_regs.exists(key) ? ref_regs[key] : 16'h0000;
				if (c.op == op_read_inc) ref_addr[p] = ref_addr[p] + 1'b1;
			end
		endcase
		return e;
	endfunction

	task automatic check_rsp(input mgmt_rsp_t got);
		expect_t want;
		int p;
		p = int'(got.port);
		assert (p < `NUM_PORTS && exp_q[p].size() > 0) else
			fail_run($sformatf("response tagged port %0d with no command outstanding", p));
		want = exp_q[p].pop_front();
		served[p]++;
		assert (got.op === want.op) else
			fail_run($sformatf("mismatch rsp.op port %0d: expected %h got %h",
				p, want.op, got.op));
		assert (got.data === want.data) else
			fail_run($sformatf("mismatch rsp.data port %0d: expected %h got %h",
				p, want.data, got.data));
		assert (frame_cnt[p] == served[p]) else
			fail_run($sformatf("port %0d phy saw %0d frames for %0d responses",
				p, frame_cnt[p], served[p]));
		assert (seen_op[p] === want.op) else
			fail_run($sformatf("mismatch seen_op port %0d: expected %h got %h",
				p, want.op, seen_op[p]));
		assert (seen_devad[p] === want.devad) else
			fail_run($sformatf("mismatch seen_devad port %0d: expected %h got %h",
				p, want.devad, seen_devad[p]));
		rsp_count++;
	endtask

	////////////////////
	// host handshakes
	////////////////////

	task automatic send_cmd(input mgmt_cmd_t c);
		@(posedge sys_clk);
		cmd <= c;
		cmd_req <= 1'b1;
		do @(posedge sys_clk); while (cmd_ack !== 1'b1);
		cmd_req <= 1'b0;
		do @(posedge sys_clk); while (cmd_ack !== 1'b0);
	endtask

	task automatic take_rsp();
		mgmt_rsp_t got;
		int hold;
		do @(posedge sys_clk); while (rsp_req !== 1'b1);
		got = rsp;
		hold = $urandom_range(5, 0);
		// a stalled host must see the response sit still
		repeat (hold) begin
			@(posedge sys_clk);
			assert (rsp === got) else
				fail_run($sformatf("mismatch rsp while held: expected %h got %h", got, rsp));
		end
		rsp_ack <= 1'b1;
		check_rsp(got);
		do @(posedge sys_clk); while (rsp_req === 1'b1);
		rsp_ack <= 1'b0;
	endtask

	initial begin
		forever take_rsp();
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		assert (cycle_cnt < TIMEOUT_CYCLES) else
			fail_run($sformatf("timeout after %0d cycles with %0d responses",
				cycle_cnt, rsp_count));
		assert (frame_err == '0) else fail_run("phy model reported a malformed frame");
	end

	initial begin : host_cmds
		mgmt_cmd_t c;
		int p;
		int leftover;
		int frames;
		void'($urandom(SEED));
		user_mode_sync = 1'b0;
		cmd = '0;
		cmd_req = 1'b0;
		rsp_ack = 1'b0;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			ref_addr[i] = '0;
			served[i] = 0;
		end
		repeat (3) @(posedge sys_clk);
		user_mode_sync <= 1'b1;
		for (int n = 0; n < NUM_CMDS; n++) begin
			p = $urandom_range(`NUM_PORTS - 1, 0);
			c.port = 3'(p);
			c.op = mdio_op_e'($urandom_range(3, 0));
			c.prtad = 5'(PRTAD_BASE + p);
			// narrow devad and address ranges so reads land on earlier writes
			c.devad = 5'($urandom_range(3, 0));
			c.data = (c.op == op_addr) ? 16'($urandom_range(7, 0)) : 16'($urandom);
			exp_q[p].push_back(predict(c));
			send_cmd(c);
		end
		while (rsp_count < NUM_CMDS) @(posedge sys_clk);
		// an extra response fails in check_rsp, an extra frame shows in the count
		repeat (SETTLE_CYCLES) @(posedge sys_clk);
		leftover = 0;
		frames = 0;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			leftover += exp_q[i].size();
			frames += frame_cnt[i];
		end
		if (leftover == 0 && frames == NUM_CMDS) begin
			$display("Everything OK");
			$finish;
		end else begin
			fail_run($sformatf("%0d responses missing and %0d frames seen for %0d commands",
				leftover, frames, NUM_CMDS));
		end
	end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/mdio_frame_pkg.sv
hdl/mgmt_if_pkg.sv
hdl/mgmt_cmd_dispatch.sv
hdl/mdio_port_engine.sv
hdl/mgmt_rsp_collect.sv
hdl/mdio_mgmt_top.sv
sim/mmd_phy_model.sv
sim/mdio_mgmt_tb.sv
